// ==== filelist.f ====
+incdir+design
design/icache_pkg.sv
design/icache_tagv.sv
design/icache_data.sv
design/icache_lru.sv
design/icache_refill.sv
design/icache_ctrl.sv
design/icache_top.sv
verif/icache_clk_gen.sv
verif/icache_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module icache_tb -f filelist.f -o icache_sim &&
./obj_dir/icache_sim | tee /dev/stderr | grep -q "All tests passed!" &&
echo "simulation passed" ||
{ echo "build or simulation failed"; exit 1; }

// ==== verif/icache_tb.sv ====
`default_nettype none

`include "icache_defines.svh"

module icache_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int WAIT_LIMIT = 400;    // cycles per wait

    logic                clk;
    logic                rst;
    logic                valid;
    logic                flush;
    icache_pkg::addr_t   pc_in;
    icache_pkg::addr_t   p_addr;
    icache_pkg::cookie_t cookie_in;
    logic                uncache;
    logic                cacop_en;
    logic [1:0]          cacop_code;
    icache_pkg::exc_t    tlb_exception;
    logic                r_rdy;
    logic                ret_valid;
    logic                ret_last;
    logic [31:0]         r_data_AXI;
    logic                data_valid;
    icache_pkg::packet_t r_data_CPU;
    icache_pkg::addr_t   pc_out;
    icache_pkg::cookie_t cookie_out;
    logic                cache_ready;
    logic                cacop_ready;
    logic                cacop_complete;
    logic                r_req;
    logic                r_data_ready;
    logic [7:0]          r_length;
    icache_pkg::addr_t   r_addr;
    icache_pkg::addr_t   badv;
    icache_pkg::exc_t    exception;

    int                  errors;
    int                  checks;
    int                  req_count;      // bus handshakes seen by the model
    int                  reqs_before;
    int                  seq;
    icache_pkg::addr_t   req_addr;
    logic [7:0]          req_len;
    icache_pkg::cookie_t sent_cookie;
    logic                dv_seen;

    icache_clk_gen clk_gen_i (
        .clk (clk),
        .rst (rst)
    );

    icache_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .flush          (flush),
        .pc_in          (pc_in),
        .p_addr         (p_addr),
        .cookie_in      (cookie_in),
        .uncache        (uncache),
        .cacop_en       (cacop_en),
        .cacop_code     (cacop_code),
        .tlb_exception  (tlb_exception),
        .r_rdy          (r_rdy),
        .ret_valid      (ret_valid),
        .ret_last       (ret_last),
        .r_data_AXI     (r_data_AXI),
        .data_valid     (data_valid),
        .r_data_CPU     (r_data_CPU),
        .pc_out         (pc_out),
        .cookie_out     (cookie_out),
        .cache_ready    (cache_ready),
        .cacop_ready    (cacop_ready),
        .cacop_complete (cacop_complete),
        .r_req          (r_req),
        .r_data_ready   (r_data_ready),
        .r_length       (r_length),
        .r_addr         (r_addr),
        .badv           (badv),
        .exception      (exception)
    );

    function automatic logic [31:0] mem_word(input icache_pkg::addr_t a);
        return a ^ 32'h5a5a0000;
    endfunction

    // page offset kept, so index and line offset match the pc
    function automatic icache_pkg::addr_t to_phys(input icache_pkg::addr_t pc);
        return pc + 32'h4000_0000;
    endfunction

    function automatic icache_pkg::packet_t expected_packet(input icache_pkg::addr_t pa);
        icache_pkg::addr_t base;
        base = {pa[31:3], 3'b000};
        return {mem_word(base + 32'd4), mem_word(base)};    // lower word first
    endfunction

    // read bus slave giving r_rdy after 0 to 3 idle cycles and then one burst
    initial begin : bus_model
        int delay;
        r_rdy      = 1'b0;
        ret_valid  = 1'b0;
        ret_last   = 1'b0;
        r_data_AXI = '0;
        req_count  = 0;
        req_addr   = '0;
        req_len    = '0;
        void'($urandom(32'h3a0af84c));
        forever begin
            @(negedge clk);
            if (r_req) begin
                req_count++;
                req_addr = r_addr;
                req_len  = r_length;
                delay    = $urandom % 4;
                repeat (delay) @(posedge clk);
                @(posedge clk);
                r_rdy <= 1'b1;
                @(posedge clk);
                r_rdy <= 1'b0;
                for (int i = 0; i <= int'(req_len); i++) begin
                    ret_valid  <= 1'b1;
                    ret_last   <= (i == int'(req_len));
                    r_data_AXI <= mem_word(req_addr + 32'(4 * i));
                    @(negedge clk);
                    check_value("r_data_ready", 64'(r_data_ready), 64'd1);
                    @(posedge clk);
                end
                ret_valid <= 1'b0;
                ret_last  <= 1'b0;
            end
        end
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        errors++;
        $display("timeout after %0d cycles waiting for %s", WAIT_LIMIT, what);
        $display("checks run: %0d, errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (rst && n < WAIT_LIMIT);
        if (rst) report_timeout("reset release");
    endtask

    // also notes any data_valid on the way
    task automatic wait_ready();
        int n;
        n       = 0;
        dv_seen = 1'b0;
        do begin
            @(negedge clk);
            n++;
            dv_seen = dv_seen | data_valid;
        end while (!cache_ready && n < WAIT_LIMIT);
        if (!cache_ready) report_timeout("cache_ready");
    endtask

    task automatic wait_answer(output int lat);
        logic got;
        lat = 0;
        got = 1'b0;
        while (!got && lat < WAIT_LIMIT) begin
            @(negedge clk);
            lat++;
            got = data_valid | cacop_complete;
        end
        if (!got) report_timeout("data_valid or cacop_complete");
    endtask

    // returns right after the accept edge
    task automatic send_request(input icache_pkg::addr_t pc, input icache_pkg::addr_t pa,
                                input logic unc, input logic cop_en, input logic [1:0] cop,
                                input icache_pkg::exc_t tlb, input logic do_flush);
        wait_ready();
        reqs_before = req_count;
        sent_cookie = 32'hc0c0_0000 + 32'(seq);
        seq++;
        @(posedge clk);
        valid      <= 1'b1;
        pc_in      <= pc;
        cookie_in  <= sent_cookie;
        uncache    <= unc;
        cacop_en   <= cop_en;
        cacop_code <= cop;
        @(posedge clk);
        valid         <= 1'b0;
        p_addr        <= pa;              // translation one cycle later
        tlb_exception <= tlb;
        flush         <= do_flush;
    endtask

    task automatic fetch_cached(input icache_pkg::addr_t pc, input logic expect_miss);
        icache_pkg::addr_t pa;
        int lat;
        pa = to_phys(pc);
        send_request(pc, pa, 1'b0, 1'b0, 2'd0, `EXP_NONE, 1'b0);
        wait_answer(lat);
        check_value("data_valid", 64'(data_valid), 64'd1);
        check_value("r_data_CPU", 64'(r_data_CPU), 64'(expected_packet(pa)));
        check_value("pc_out", 64'(pc_out), 64'(pc));
        check_value("cookie_out", 64'(cookie_out), 64'(sent_cookie));
        check_value("exception", 64'(exception), 64'(`EXP_NONE));
        check_value("badv", 64'(badv), 64'd0);
        if (expect_miss) begin
            check_value("r_req count", 64'(req_count - reqs_before), 64'd1);
            check_value("r_addr", 64'(req_addr), 64'({pa[31:6], 6'b0}));
            check_value("r_length", 64'(req_len), 64'd15);
        end else begin
            check_value("r_req count", 64'(req_count - reqs_before), 64'd0);
            check_value("hit latency", 64'(lat), 64'd2);
        end
    endtask

    task automatic fetch_uncached(input icache_pkg::addr_t pc);
        icache_pkg::addr_t pa;
        int lat;
        pa = to_phys(pc);
        send_request(pc, pa, 1'b1, 1'b0, 2'd0, `EXP_NONE, 1'b0);
        wait_answer(lat);
        check_value("data_valid", 64'(data_valid), 64'd1);
        check_value("r_data_CPU", 64'(r_data_CPU), 64'(expected_packet(pa)));
        check_value("cookie_out", 64'(cookie_out), 64'(sent_cookie));
        check_value("r_req count", 64'(req_count - reqs_before), 64'd1);
        check_value("r_addr", 64'(req_addr), 64'({pa[31:3], 3'b0}));
        check_value("r_length", 64'(req_len), 64'd1);
    endtask

    task automatic fetch_fault(input icache_pkg::addr_t pc, input icache_pkg::exc_t tlb,
                               input icache_pkg::exc_t exp_exc);
        int lat;
        send_request(pc, to_phys(pc), 1'b0, 1'b0, 2'd0, tlb, 1'b0);
        wait_answer(lat);
        check_value("data_valid", 64'(data_valid), 64'd1);
        check_value("fault latency", 64'(lat), 64'd2);
        check_value("exception", 64'(exception), 64'(exp_exc));
        check_value("pc_out", 64'(pc_out), 64'(pc));
        check_value("badv", 64'(badv), 64'(pc));
        check_value("r_req count", 64'(req_count - reqs_before), 64'd0);
    endtask

    task automatic cache_op(input icache_pkg::addr_t pc, input logic [1:0] code);
        int lat;
        send_request(pc, to_phys(pc), 1'b0, 1'b1, code, `EXP_NONE, 1'b0);
        wait_answer(lat);
        check_value("cacop_complete", 64'(cacop_complete), 64'd1);
        check_value("data_valid", 64'(data_valid), 64'd0);
        check_value("cacop latency", 64'(lat), 64'd2);
        check_value("r_req count", 64'(req_count - reqs_before), 64'd0);
    endtask

    task automatic test_reset_values();
        check_value("r_req", 64'(r_req), 64'd0);
        check_value("data_valid", 64'(data_valid), 64'd0);
        check_value("cacop_complete", 64'(cacop_complete), 64'd0);
        check_value("r_data_ready", 64'(r_data_ready), 64'd0);
        check_value("cache_ready", 64'(cache_ready), 64'd1);
        check_value("cacop_ready", 64'(cacop_ready), 64'd1);
    endtask

    task automatic test_miss_then_hit();
        fetch_cached(32'h0000_1048, 1'b1);
        fetch_cached(32'h0000_1048, 1'b0);
        fetch_cached(32'h0000_1070, 1'b0);    // other packet, same line
    endtask

    // five tags on set 5, tree order puts the fifth over the first
    task automatic test_lru_eviction();
        for (int k = 0; k < 5; k++) begin
            fetch_cached(32'h0000_0140 + 32'(k * 32'h1000), 1'b1);
        end
        fetch_cached(32'h0000_0140, 1'b1);
        fetch_cached(32'h0000_3140, 1'b0);
    endtask

    task automatic test_uncached();
        fetch_uncached(32'h0000_2294);
        fetch_uncached(32'h0000_2294);
    endtask

    task automatic test_exceptions();
        fetch_fault(32'h0000_3002, `EXP_NONE, `EXP_ADEF);
        fetch_fault(32'h0000_3100, 7'h02, 7'h02);
        fetch_cached(32'h0000_3100, 1'b1);    // fault left no line behind
    endtask

    task automatic test_cache_ops();
        fetch_cached(32'h0000_0380, 1'b1);
        fetch_cached(32'h0000_0380, 1'b0);
        cache_op(32'h0000_0380, 2'd0);
        fetch_cached(32'h0000_0380, 1'b1);
        cache_op(32'h0000_0380, 2'd2);
        fetch_cached(32'h0000_0380, 1'b1);
    endtask

    task automatic test_flush();
        send_request(32'h0000_0500, to_phys(32'h0000_0500), 1'b0, 1'b0, 2'd0,
                     `EXP_NONE, 1'b1);
        @(posedge clk);
        flush <= 1'b0;
        wait_ready();
        check_value("data_valid after flush", 64'(dv_seen), 64'd0);
        check_value("r_req count", 64'(req_count - reqs_before), 64'd1);
        fetch_cached(32'h0000_0500, 1'b0);    // fill still landed
    endtask

    initial begin
        errors        = 0;
        checks        = 0;
        seq           = 0;
        valid         = 1'b0;
        flush         = 1'b0;
        pc_in         = '0;
        p_addr        = '0;
        cookie_in     = '0;
        uncache       = 1'b0;
        cacop_en      = 1'b0;
        cacop_code    = 2'd0;
        tlb_exception = `EXP_NONE;
        wait_reset_release();
        test_reset_values();
        test_miss_then_hit();
        test_lru_eviction();
        test_uncached();
        test_exceptions();
        test_cache_ops();
        test_flush();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/icache_clk_gen.sv ====
`default_nettype none

module icache_clk_gen (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;    // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== design/icache_top.sv ====
`default_nettype none

module icache_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                valid,
    input  logic                flush,
    input  icache_pkg::addr_t   pc_in,
    input  icache_pkg::addr_t   p_addr,
    input  icache_pkg::cookie_t cookie_in,
    input  logic                uncache,
    input  logic                cacop_en,
    input  logic [1:0]          cacop_code,
    input  icache_pkg::exc_t    tlb_exception,
    input  logic                r_rdy,
    input  logic                ret_valid,
    input  logic                ret_last,
    input  logic [31:0]         r_data_AXI,
    output logic                data_valid,
    output icache_pkg::packet_t r_data_CPU,
    output icache_pkg::addr_t   pc_out,
    output icache_pkg::cookie_t cookie_out,
    output logic                cache_ready,
    output logic                cacop_ready,
    output logic                cacop_complete,
    output logic                r_req,
    output logic                r_data_ready,
    output logic [7:0]          r_length,
    output icache_pkg::addr_t   r_addr,
    output icache_pkg::addr_t   badv,
    output icache_pkg::exc_t    exception
);

    icache_pkg::addr_t    pc_q;
    icache_pkg::cookie_t  cookie_q;
    logic                 uncache_q;
    logic                 cacop_en_q;
    logic [1:0]           cacop_code_q;
    logic                 req_valid_q;    // cleared by flush
    icache_pkg::addr_t    paddr_q;
    icache_pkg::exc_t     tlb_exc_q;

    logic                 rbuf_we;
    logic                 pbuf_we;
    logic                 lru_en;
    logic                 rdata_sel;
    logic                 fill_finish;
    logic                 cache_hit;
    logic                 ctrl_data_valid;
    icache_pkg::way_vec_t hit;
    icache_pkg::way_vec_t data_hit;
    icache_pkg::way_vec_t victim;
    icache_pkg::way_vec_t visit;
    icache_pkg::way_vec_t tagv_we;
    icache_pkg::way_vec_t mem_we;
    icache_pkg::way_vec_t tagv_clear;
    icache_pkg::line_t    line;
    icache_pkg::index_t   rd_index;
    icache_pkg::tag_t     cur_tag;
    icache_pkg::exc_t     cur_tlb_exc;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_valid_q  <= 1'b0;
            pc_q         <= '0;
            uncache_q    <= 1'b0;
            cacop_en_q   <= 1'b0;
            cacop_code_q <= '0;
            tlb_exc_q    <= '0;
        end else begin
            if (flush) begin
                req_valid_q <= 1'b0;
            end else if (rbuf_we) begin
                req_valid_q <= valid;
            end
            if (rbuf_we) begin
                pc_q         <= pc_in;
                uncache_q    <= uncache;
                cacop_en_q   <= cacop_en;
                cacop_code_q <= cacop_code;
            end
            if (pbuf_we) begin
                tlb_exc_q <= tlb_exception;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rbuf_we) begin
            cookie_q <= cookie_in;
        end
        if (pbuf_we) begin
            paddr_q <= p_addr;
        end
    end

    // arrays are read at accept, translation is used in the lookup cycle
    assign rd_index    = rbuf_we ? pc_in[11:6] : pc_q[11:6];
    assign cur_tag     = pbuf_we ? p_addr[31:12] : paddr_q[31:12];
    assign cur_tlb_exc = pbuf_we ? tlb_exception : tlb_exc_q;
    assign data_hit    = uncache_q ? '0 : hit;   // uncached never reads the arrays

    assign r_addr     = uncache_q ? {paddr_q[31:3], 3'b0} : {paddr_q[31:6], 6'b0};
    assign pc_out     = pc_q;
    assign cookie_out = cookie_q;
    assign badv       = (|exception) ? pc_q : '0;
    assign data_valid = ctrl_data_valid & req_valid_q;

    icache_tagv tagv_i (
        .clk        (clk),
        .rst        (rst),
        .r_index    (rd_index),
        .p_tag      (cur_tag),
        .w_index    (pc_q[11:6]),
        .we         (tagv_we),
        .tagv_clear (tagv_clear),
        .hit        (hit),
        .cache_hit  (cache_hit)
    );

    icache_data data_i (
        .clk          (clk),
        .r_index      (rd_index),
        .w_index      (pc_q[11:6]),
        .offset       (pc_q[5:3]),
        .hit          (data_hit),
        .mem_we       (mem_we),
        .fill_line    (line),
        .rdata_sel    (rdata_sel),
        .uncache_word (line[63:0]),
        .r_data       (r_data_CPU)
    );

    icache_lru lru_i (
        .clk    (clk),
        .rst    (rst),
        .index  (pc_q[11:6]),
        .visit  (visit),
        .en     (lru_en),
        .victim (victim)
    );

    icache_refill refill_i (
        .clk         (clk),
        .rst         (rst),
        .ret_valid   (ret_valid),
        .ret_last    (ret_last),
        .data        (r_data_AXI),
        .line        (line),
        .fill_finish (fill_finish)
    );

    icache_ctrl ctrl_i (
        .clk            (clk),
        .rst            (rst),
        .valid          (valid),
        .cache_hit      (cache_hit),
        .hit            (hit),
        .victim         (victim),
        .uncache        (uncache_q),
        .cacop_en       (cacop_en_q),
        .cacop_code     (cacop_code_q),
        .pc_low         (pc_q[1:0]),
        .tlb_exception  (cur_tlb_exc),
        .r_rdy          (r_rdy),
        .fill_finish    (fill_finish),
        .rbuf_we        (rbuf_we),
        .pbuf_we        (pbuf_we),
        .tagv_we        (tagv_we),
        .mem_we         (mem_we),
        .tagv_clear     (tagv_clear),
        .lru_en         (lru_en),
        .visit          (visit),
        .rdata_sel      (rdata_sel),
        .r_req          (r_req),
        .r_length       (r_length),
        .r_data_ready   (r_data_ready),
        .data_valid     (ctrl_data_valid),
        .cache_ready    (cache_ready),
        .cacop_ready    (cacop_ready),
        .cacop_complete (cacop_complete),
        .exception      (exception)
    );

endmodule

`default_nettype wire

// ==== design/icache_ctrl.sv ====
`default_nettype none

`include "icache_defines.svh"

module icache_ctrl (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid,
    input  logic                 cache_hit,
    input  icache_pkg::way_vec_t hit,
    input  icache_pkg::way_vec_t victim,
    input  logic                 uncache,
    input  logic                 cacop_en,
    input  logic [1:0]           cacop_code,
    input  logic [1:0]           pc_low,
    input  icache_pkg::exc_t     tlb_exception,
    input  logic                 r_rdy,
    input  logic                 fill_finish,
    output logic                 rbuf_we,
    output logic                 pbuf_we,
    output icache_pkg::way_vec_t tagv_we,
    output icache_pkg::way_vec_t mem_we,
    output icache_pkg::way_vec_t tagv_clear,
    output logic                 lru_en,
    output icache_pkg::way_vec_t visit,
    output logic                 rdata_sel,
    output logic                 r_req,
    output logic [7:0]           r_length,
    output logic                 r_data_ready,
    output logic                 data_valid,
    output logic                 cache_ready,
    output logic                 cacop_ready,
    output logic                 cacop_complete,
    output icache_pkg::exc_t     exception
);

    icache_pkg::ctrl_state_t state;
    icache_pkg::ctrl_state_t state_nxt;
    icache_pkg::way_vec_t    victim_q;

    // address error wins over a translator fault; cache ops never trap here
    always_comb begin
        if (cacop_en) begin
            exception = `EXP_NONE;
        end else if (pc_low != 2'b00) begin
            exception = `EXP_ADEF;
        end else begin
            exception = tlb_exception;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= icache_pkg::idle;
            victim_q  <= '0;
            rdata_sel <= 1'b0;
        end else begin
            state     <= state_nxt;
            rdata_sel <= (state == icache_pkg::refill) && fill_finish;
            if (state == icache_pkg::lookup && !cache_hit) begin
                victim_q <= victim;                  // way to refill
            end
        end
    end

    always_comb begin
        state_nxt      = state;
        rbuf_we        = 1'b0;
        pbuf_we        = 1'b0;
        tagv_we        = '0;
        mem_we         = '0;
        tagv_clear     = '0;
        lru_en         = 1'b0;
        visit          = '0;
        r_req          = 1'b0;
        r_data_ready   = 1'b0;
        data_valid     = 1'b0;
        cache_ready    = 1'b0;
        cacop_complete = 1'b0;
        unique case (state)
            icache_pkg::idle: begin
                cache_ready = 1'b1;
                rbuf_we     = valid;
                if (valid) begin
                    state_nxt = icache_pkg::lookup;
                end
            end
            icache_pkg::lookup: begin
                pbuf_we = 1'b1;                      // p_addr arrives now
                if (cacop_en) begin
                    state_nxt = icache_pkg::cacop;
                end else if (exception != `EXP_NONE) begin
                    state_nxt = icache_pkg::respond; // no access
                end else if (uncache) begin
                    state_nxt = icache_pkg::uncache_req;
                end else if (cache_hit) begin
                    lru_en    = 1'b1;
                    visit     = hit;
                    state_nxt = icache_pkg::respond;
                end else begin
                    state_nxt = icache_pkg::miss_req;
                end
            end
            icache_pkg::miss_req: begin
                r_req = 1'b1;
                if (r_rdy) begin
                    state_nxt = icache_pkg::refill;
                end
            end
            icache_pkg::refill: begin
                r_data_ready = 1'b1;
                if (fill_finish) begin
                    tagv_we   = victim_q;
                    mem_we    = victim_q;
                    lru_en    = 1'b1;
                    visit     = victim_q;
                    state_nxt = icache_pkg::respond;
                end
            end
            icache_pkg::uncache_req: begin
                r_req = 1'b1;
                if (r_rdy) begin
                    state_nxt = icache_pkg::uncache_wait;
                end
            end
            icache_pkg::uncache_wait: begin
                r_data_ready = 1'b1;
                if (fill_finish) begin
                    state_nxt = icache_pkg::respond;
                end
            end
            icache_pkg::cacop: begin
                cacop_complete = 1'b1;
                case (cacop_code)
                    2'd0:    tagv_clear = '1;        // index invalidate, all ways
                    2'd2:    tagv_clear = hit;       // hit invalidate
                    default: tagv_clear = '0;
                endcase
                state_nxt = icache_pkg::idle;
            end
            icache_pkg::respond: begin
                data_valid  = 1'b1;
                cache_ready = 1'b1;
                rbuf_we     = valid;                 // back-to-back accept
                state_nxt   = valid ? icache_pkg::lookup : icache_pkg::idle;
            end
            default: begin
                state_nxt = icache_pkg::idle;
            end
        endcase
    end

    assign cacop_ready = cache_ready;
    assign r_length    = (state == icache_pkg::miss_req) ? 8'd15 : 8'd1;

endmodule

`default_nettype wire

// ==== design/icache_refill.sv ====
`default_nettype none

`include "icache_defines.svh"

module icache_refill (
    input  logic              clk,
    input  logic              rst,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  logic [31:0]       data,
    output icache_pkg::line_t line,
    output logic              fill_finish
);

    localparam int CNT_W = $clog2(`ICACHE_LINE_BEATS);

    logic [CNT_W-1:0] beat_cnt;

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt    <= '0;
            fill_finish <= 1'b0;
        end else begin
            fill_finish <= ret_valid & ret_last;
            if (ret_valid) begin
                beat_cnt <= ret_last ? '0 : beat_cnt + 1'b1;   // ready for next burst
            end
        end
    end

    // beat n lands in word n of the line
    always_ff @(posedge clk) begin
        if (ret_valid) begin
            line[{beat_cnt, 5'b0} +: 32] <= data;
        end
    end

endmodule

`default_nettype wire

// ==== design/icache_lru.sv ====
`default_nettype none

`include "icache_defines.svh"

module icache_lru (
    input  logic                 clk,
    input  logic                 rst,
    input  icache_pkg::index_t   index,
    input  icache_pkg::way_vec_t visit,
    input  logic                 en,
    output icache_pkg::way_vec_t victim
);

    // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3; each points at the victim side
    logic [2:0] tree [`ICACHE_SETS];
    logic [2:0] cur;

    assign cur = tree[index];

    always_comb begin
        if (cur[0]) begin
            victim = cur[2] ? 4'b1000 : 4'b0100;
        end else begin
            victim = cur[1] ? 4'b0010 : 4'b0001;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (en) begin
            if (visit[0]) begin
                tree[index] <= {cur[2], 1'b1, 1'b1};
            end else if (visit[1]) begin
                tree[index] <= {cur[2], 1'b0, 1'b1};
            end else if (visit[2]) begin
                tree[index] <= {1'b1, cur[1], 1'b0};
            end else if (visit[3]) begin
                tree[index] <= {1'b0, cur[1], 1'b0};
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/icache_data.sv ====
`default_nettype none

`include "icache_defines.svh"

module icache_data (
    input  logic                 clk,
    input  icache_pkg::index_t   r_index,
    input  icache_pkg::index_t   w_index,
    input  logic [2:0]           offset,
    input  icache_pkg::way_vec_t hit,
    input  icache_pkg::way_vec_t mem_we,
    input  icache_pkg::line_t    fill_line,
    input  logic                 rdata_sel,
    input  icache_pkg::packet_t  uncache_word,
    output icache_pkg::packet_t  r_data
);

    icache_pkg::line_t mem     [`ICACHE_WAYS][`ICACHE_SETS];
    icache_pkg::line_t rd_line [`ICACHE_WAYS];
    icache_pkg::line_t sel_line;

    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            rd_line[w] <= mem[w][r_index];
            if (mem_we[w]) begin
                mem[w][w_index] <= fill_line;
            end
        end
    end

    always_comb begin
        sel_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit[w]) begin
                sel_line = sel_line | rd_line[w];   // hit is one-hot
            end
        end
        if (rdata_sel) begin
            sel_line = fill_line;                   // bypass right after a fill
        end
        if (rdata_sel || (|hit)) begin
            r_data = sel_line[{offset, 6'b0} +: 64];
        end else begin
            r_data = uncache_word;
        end
    end

endmodule

`default_nettype wire

// ==== design/icache_tagv.sv ====
`default_nettype none

`include "icache_defines.svh"

module icache_tagv (
    input  logic                 clk,
    input  logic                 rst,
    input  icache_pkg::index_t   r_index,
    input  icache_pkg::tag_t     p_tag,
    input  icache_pkg::index_t   w_index,
    input  icache_pkg::way_vec_t we,
    input  icache_pkg::way_vec_t tagv_clear,
    output icache_pkg::way_vec_t hit,
    output logic                 cache_hit
);

    icache_pkg::tag_t        tag_mem [`ICACHE_WAYS][`ICACHE_SETS];
    icache_pkg::tag_t        tag_rd  [`ICACHE_WAYS];
    logic [`ICACHE_SETS-1:0] valid_bits [`ICACHE_WAYS];
    icache_pkg::way_vec_t    valid_rd;

    // tag ram, synchronous read
    always_ff @(posedge clk) begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            tag_rd[w] <= tag_mem[w][r_index];
            if (we[w]) begin
                tag_mem[w][w_index] <= p_tag;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_rd <= '0;
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_bits[w] <= '0;
            end
        end else begin
            for (int w = 0; w < `ICACHE_WAYS; w++) begin
                valid_rd[w] <= valid_bits[w][r_index];
                if (we[w]) begin
                    valid_bits[w][w_index] <= 1'b1;          // fill sets valid
                end else if (tagv_clear[w]) begin
                    valid_bits[w][w_index] <= 1'b0;          // cacop invalidate
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            hit[w] = valid_rd[w] && (tag_rd[w] == p_tag);
        end
    end

    assign cache_hit = |hit;

endmodule

`default_nettype wire

// ==== design/icache_pkg.sv ====
`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

    typedef logic [31:0]                       addr_t;
    typedef logic [19:0]                       tag_t;     // paddr[31:12]
    typedef logic [5:0]                        index_t;   // addr[11:6]
    typedef logic [`ICACHE_WAYS-1:0]           way_vec_t; // one-hot
    typedef logic [`ICACHE_LINE_BEATS*32-1:0]  line_t;
    typedef logic [63:0]                       packet_t;  // two instructions
    typedef logic [`ICACHE_COOKIE_W-1:0]       cookie_t;
    typedef logic [6:0]                        exc_t;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss_req,
        refill,
        uncache_req,
        uncache_wait,
        cacop,
        respond
    } ctrl_state_t;

endpackage

`default_nettype wire

// ==== design/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry
`define ICACHE_WAYS       4
`define ICACHE_SETS       64
`define ICACHE_LINE_BEATS 16    // 32-bit beats per line

`define ICACHE_COOKIE_W   32    // returned untouched with the answer

// exception codes
`define EXP_NONE          7'h00
`define EXP_ADEF          7'h08 // fetch address error

`endif
